// File: flist.f
+incdir+hw
hw/cuPkg.sv
hw/instrDecoder.sv
hw/stepCounter.sv
hw/phaseFsm.sv
hw/controlWordGen.sv
hw/controlUnit.sv
tb/controlUnitTb.sv

// File: hw/controlUnit.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module controlUnit
(
	input  logic                 Clk,
	input  logic                 RESET,
	input  logic [`WORD_W-1:0]   irOut,
	input  logic                 MFC,
	output cuPkg::enables_t      enables,
	output cuPkg::clears_t       clears,
	output cuPkg::muxSel_t       muxSel,
	output cuPkg::regAddr_t      regAddr,
	output logic [`ALU_OP_W-1:0] aluOp,
	output logic [`ALU_OP_W-1:0] ramOpCode
);

	cuPkg::instrClass_e  instrClass;
	cuPkg::instrFields_t fields;
	cuPkg::phase_e       phase;
	logic                restart;
	logic                hold;
	logic                last;
	logic [`STEP_W-1:0]  length;
	logic [`STEP_W-1:0]  step;

	instrDecoder decoder
	(
		.irOut      (irOut),
		.instrClass (instrClass),
		.fields     (fields)
	);

	// Sequencing
	phaseFsm fsm
	(
		.Clk        (Clk),
		.RESET      (RESET),
		.MFC        (MFC),
		.instrClass (instrClass),
		.last       (last),
		.phase      (phase),
		.restart    (restart),
		.hold       (hold),
		.length     (length)
	);

	stepCounter counter
	(
		.Clk     (Clk),
		.RESET   (RESET),
		.restart (restart),
		.hold    (hold),
		.length  (length),
		.step    (step),
		.last    (last)
	);

	// Outputs to the datapath
	controlWordGen wordGen
	(
		.phase     (phase),
		.step      (step),
		.fields    (fields),
		.enables   (enables),
		.clears    (clears),
		.muxSel    (muxSel),
		.regAddr   (regAddr),
		.ramOpCode (ramOpCode),
		.aluOp     (aluOp)
	);

endmodule

// File: hw/controlWordGen.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module controlWordGen
(
	input  cuPkg::phase_e         phase,
	input  logic [`STEP_W-1:0]    step,
	input  cuPkg::instrFields_t   fields,
	output cuPkg::enables_t       enables,
	output cuPkg::clears_t        clears,
	output cuPkg::muxSel_t        muxSel,
	output cuPkg::regAddr_t       regAddr,
	output logic [`ALU_OP_W-1:0]  ramOpCode,
	output logic [`ALU_OP_W-1:0]  aluOp
);

	logic            step0;
	logic            step1;
	logic            step2;
	logic            isSethi;
	cuPkg::aluBSel_e operandB;

	assign step0 = (step == `STEP_W'(0));
	assign step1 = (step == `STEP_W'(1));
	assign step2 = (step == `STEP_W'(2));

	// Tag left by the decoder, only meaningful in EXEC
	assign isSethi = (fields.op3 == `OP3_JMPL);

	// Second operand, simm13 or rs2
	assign operandB = fields.imm ? cuPkg::B_EXTENDER : cuPkg::B_REGPORT;

	always_comb
	begin
		enables     = '0;
		clears      = '0;
		muxSel.aluA = cuPkg::A_REGPORT;
		muxSel.aluB = cuPkg::B_REGPORT;
		muxSel.ext  = cuPkg::EXT_SIMM13;
		muxSel.pcIn = cuPkg::PCIN_NPC;
		muxSel.mdr  = cuPkg::MDR_REGPORT;
		regAddr     = '0;
		aluOp       = `ALU_ADD;
		ramOpCode   = `RAM_LOAD_WORD;
		case (phase)
			cuPkg::INIT:
			begin
				clears.pcClr  = step0;
				clears.psrClr = step0;
				muxSel.aluA   = cuPkg::A_CONST; // 0 + 4 into NPC
				muxSel.aluB   = cuPkg::B_FOUR;
				enables.npcEn = step2;
			end
			cuPkg::FETCH:
			begin
				muxSel.aluB   = cuPkg::B_PC; // r0 + PC to MAR
				enables.marEn = step1;
				enables.ramEn = step2;
			end
			cuPkg::FETCHWAIT:
			begin
				muxSel.aluB   = cuPkg::B_PC;
				enables.ramEn = 1'b1;
			end
			cuPkg::IRLOAD:
				enables.irEn = 1'b1;
			cuPkg::EXEC:
			begin
				regAddr.inPC = fields.rd;
				enables.rfEn = step1;
				if (isSethi)
				begin
					muxSel.ext  = cuPkg::EXT_IMM22HI; // imm22 << 10, plus r0
					muxSel.aluB = cuPkg::B_EXTENDER;
				end
				else
				begin
					aluOp         = fields.op3;
					regAddr.inPA  = fields.rs1;
					regAddr.inPB  = fields.rs2;
					muxSel.aluB   = operandB;
					enables.psrEn = step1 & fields.setCc; // Flags only for cc forms
				end
			end
			cuPkg::ADDR:
			begin
				regAddr.inPA  = fields.rs1; // Effective address
				regAddr.inPB  = fields.rs2;
				muxSel.aluB   = operandB;
				ramOpCode     = fields.op3;
				enables.marEn = step1;
			end
			cuPkg::STDATA:
			begin
				regAddr.inPA  = fields.rd; // Store data from rd
				ramOpCode     = fields.op3;
				enables.mdrEn = step1;
			end
			cuPkg::MEMWAIT:
			begin
				ramOpCode     = fields.op3;
				muxSel.mdr    = cuPkg::MDR_MEMORY;
				enables.ramEn = 1'b1;
			end
			cuPkg::MDRLOAD:
			begin
				ramOpCode     = fields.op3;
				muxSel.mdr    = cuPkg::MDR_MEMORY;
				muxSel.aluB   = cuPkg::B_MDR;
				regAddr.inPC  = fields.rd;
				enables.mdrEn = 1'b1;
			end
			cuPkg::RFWRITE:
			begin
				ramOpCode    = fields.op3;
				muxSel.aluB  = cuPkg::B_MDR; // r0 + MDR to rd
				regAddr.inPC = fields.rd;
				enables.rfEn = 1'b1;
			end
			cuPkg::PCADV:
			begin
				muxSel.aluA   = cuPkg::A_NPC; // NPC -> PC, NPC + 4 -> NPC
				muxSel.aluB   = cuPkg::B_FOUR;
				muxSel.pcIn   = cuPkg::PCIN_NPC;
				enables.pcEn  = step1;
				enables.npcEn = step1;
			end
			default:
				aluOp = `ALU_ADD; // DECODE drives nothing
		endcase
	end

endmodule

// File: hw/cuPkg.sv
`include "cu_consts.svh"

package cuPkg;

	// Control phases, one or more cycles each
	typedef enum logic [3:0]
	{
		INIT      = 4'd0,
		FETCH     = 4'd1,
		FETCHWAIT = 4'd2, // Waits on MFC
		IRLOAD    = 4'd3,
		DECODE    = 4'd4,
		EXEC      = 4'd5,
		ADDR      = 4'd6,
		STDATA    = 4'd7,
		MEMWAIT   = 4'd8, // Waits on MFC
		MDRLOAD   = 4'd9,
		RFWRITE   = 4'd10,
		PCADV     = 4'd11
	} phase_e;

	typedef enum logic [2:0] {SETHI, ARITH, LOAD, STORE, OTHER} instrClass_e;

	// Mux select encodings as seen by the datapath
	typedef enum logic [1:0] {A_REGPORT = 2'b00, A_CONST = 2'b01, A_NPC = 2'b10} aluASel_e;

	typedef enum logic [2:0]
	{
		B_REGPORT  = 3'b000,
		B_EXTENDER = 3'b001,
		B_MDR      = 3'b010,
		B_PC       = 3'b011,
		B_FOUR     = 3'b110 // Constant 4 for PC stepping
	} aluBSel_e;

	typedef enum logic [2:0] {EXT_SIMM13 = 3'b000, EXT_IMM22HI = 3'b100} extSel_e;
	typedef enum logic [1:0] {PCIN_NPC = 2'b00, PCIN_ALU = 2'b01} pcInSel_e;
	typedef enum logic {MDR_REGPORT = 1'b0, MDR_MEMORY = 1'b1} mdrSel_e;

	// Load enables, all one-cycle pulses except ramEn
	typedef struct packed
	{
		logic irEn;
		logic npcEn;
		logic pcEn;
		logic mdrEn;
		logic marEn;
		logic rfEn;
		logic ramEn; // Level, held through the MFC wait
		logic psrEn;
	} enables_t;

	typedef struct packed
	{
		logic pcClr;
		logic psrClr;
	} clears_t;

	typedef struct packed
	{
		aluASel_e aluA;
		aluBSel_e aluB;
		extSel_e  ext;
		pcInSel_e pcIn;
		mdrSel_e  mdr;
	} muxSel_t;

	// Register file ports
	typedef struct packed
	{
		logic [`REG_ADDR_W-1:0] inPC; // Write address
		logic [`REG_ADDR_W-1:0] inPA;
		logic [`REG_ADDR_W-1:0] inPB;
	} regAddr_t;

	typedef struct packed
	{
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`ALU_OP_W-1:0]   op3;
		logic                   imm;
		logic                   setCc;
	} instrFields_t;

endpackage

// File: hw/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Datapath widths
`define WORD_W      32
`define REG_ADDR_W  5
`define ALU_OP_W    6 // ALU and RAM opcodes share this width

// Instruction field positions
`define OP_HI   31
`define OP_LO   30
`define RD_HI   29
`define RD_LO   25
`define OP2_HI  24
`define OP2_LO  22
`define OP3_HI  24
`define OP3_LO  19
`define RS1_HI  18
`define RS1_LO  14
`define I_BIT   13 // Immediate operand flag
`define RS2_HI  4
`define RS2_LO  0
`define CC_BIT  23 // op3 bit 4, set-condition-codes flag

// Instruction formats (op field)
`define OP_FMT2  2'b00 // SETHI and branches
`define OP_ARITH 2'b10
`define OP_MEM   2'b11

// Memory op3 codes
`define OP3_LDUW 6'd0
`define OP3_LDUB 6'd1
`define OP3_LDUH 6'd2
`define OP3_LDSB 6'd9
`define OP3_LDSH 6'd10
`define OP3_STW  6'd4
`define OP3_STB  6'd5
`define OP3_STH  6'd6
`define OP3_JMPL 6'h38 // Excluded from arithmetic

`define OP2_SETHI     3'b100
`define ALU_ADD       6'd0
`define RAM_LOAD_WORD 6'd0
`define REG_LINK      5'd15 // Return address register for CALL

// Micro-step counter and phase lengths in cycles
`define STEP_W      2
`define LEN_INIT    `STEP_W'(3)
`define LEN_FETCH   `STEP_W'(3)
`define LEN_EXEC    `STEP_W'(3)
`define LEN_ADDR    `STEP_W'(2)
`define LEN_STDATA  `STEP_W'(2)
`define LEN_PCADV   `STEP_W'(3)

`endif

// File: hw/instrDecoder.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module instrDecoder
(
	input  logic [`WORD_W-1:0]  irOut,
	output cuPkg::instrClass_e  instrClass,
	output cuPkg::instrFields_t fields
);

	logic [1:0]           op;
	logic [2:0]           op2;
	logic [`ALU_OP_W-1:0] op3;

	assign op  = irOut[`OP_HI:`OP_LO];
	assign op2 = irOut[`OP2_HI:`OP2_LO];
	assign op3 = irOut[`OP3_HI:`OP3_LO];

	// Instruction class from op, op2 and op3
	always_comb
	begin
		instrClass = cuPkg::OTHER; // Unknown codes fall through as no-ops
		case (op)
			`OP_FMT2:
				if (op2 == `OP2_SETHI)
					instrClass = cuPkg::SETHI;
			`OP_ARITH:
				if (op3 != `OP3_JMPL)
					instrClass = cuPkg::ARITH;
			`OP_MEM:
				case (op3)
					`OP3_LDUW, `OP3_LDUB, `OP3_LDUH, `OP3_LDSB, `OP3_LDSH:
						instrClass = cuPkg::LOAD;
					`OP3_STW, `OP3_STB, `OP3_STH:
						instrClass = cuPkg::STORE;
					default:
						instrClass = cuPkg::OTHER;
				endcase
			default:
				instrClass = cuPkg::OTHER; // CALL and branches
		endcase
	end

	always_comb
	begin
		fields.rd    = irOut[`RD_HI:`RD_LO];
		fields.rs1   = irOut[`RS1_HI:`RS1_LO];
		fields.rs2   = irOut[`RS2_HI:`RS2_LO];
		fields.op3   = op3;
		fields.imm   = irOut[`I_BIT];
		fields.setCc = irOut[`CC_BIT];
		// SETHI is tagged with the JMPL code, which never reaches EXEC as arithmetic
		if (instrClass == cuPkg::SETHI)
			fields.op3 = `OP3_JMPL;
	end

endmodule

// File: hw/phaseFsm.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module phaseFsm
(
	input  logic               Clk,
	input  logic               RESET,
	input  logic               MFC,
	input  cuPkg::instrClass_e instrClass,
	input  logic               last,
	output cuPkg::phase_e      phase,
	output logic               restart,
	output logic               hold,
	output logic [`STEP_W-1:0] length
);

	cuPkg::phase_e phaseNext;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			phase <= cuPkg::INIT;
		else
			phase <= phaseNext;
	end

	// Phase length and wait flag
	always_comb
	begin
		hold   = 1'b0;
		length = `STEP_W'(1); // Single-cycle phases
		case (phase)
			cuPkg::INIT:      length = `LEN_INIT;
			cuPkg::FETCH:     length = `LEN_FETCH;
			cuPkg::EXEC:      length = `LEN_EXEC;
			cuPkg::ADDR:      length = `LEN_ADDR;
			cuPkg::STDATA:    length = `LEN_STDATA;
			cuPkg::PCADV:     length = `LEN_PCADV;
			cuPkg::FETCHWAIT,
			cuPkg::MEMWAIT:   hold = 1'b1; // Ended by MFC only
			default:          hold = 1'b0;
		endcase
	end

	// Leave the phase on its last step, or on MFC while waiting
	assign restart = hold ? MFC : last;

	always_comb
	begin
		phaseNext = phase;
		if (restart)
		begin
			case (phase)
				cuPkg::INIT:      phaseNext = cuPkg::FETCH;
				cuPkg::FETCH:     phaseNext = cuPkg::FETCHWAIT;
				cuPkg::FETCHWAIT: phaseNext = cuPkg::IRLOAD;
				cuPkg::IRLOAD:    phaseNext = cuPkg::DECODE;
				cuPkg::DECODE:
				begin
					case (instrClass)
						cuPkg::SETHI,
						cuPkg::ARITH: phaseNext = cuPkg::EXEC;
						cuPkg::LOAD,
						cuPkg::STORE: phaseNext = cuPkg::ADDR;
						default:      phaseNext = cuPkg::PCADV; // No-op
					endcase
				end
				cuPkg::EXEC:      phaseNext = cuPkg::PCADV;
				cuPkg::ADDR:
					// Stores stage the data word first
					phaseNext = (instrClass == cuPkg::STORE) ? cuPkg::STDATA : cuPkg::MEMWAIT;
				cuPkg::STDATA:    phaseNext = cuPkg::MEMWAIT;
				cuPkg::MEMWAIT:
					phaseNext = (instrClass == cuPkg::LOAD) ? cuPkg::MDRLOAD : cuPkg::PCADV;
				cuPkg::MDRLOAD:   phaseNext = cuPkg::RFWRITE;
				cuPkg::RFWRITE:   phaseNext = cuPkg::PCADV;
				cuPkg::PCADV:     phaseNext = cuPkg::FETCH;
				default:          phaseNext = cuPkg::INIT;
			endcase
		end
	end

endmodule

// File: hw/stepCounter.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module stepCounter
(
	input  logic              Clk,
	input  logic              RESET,
	input  logic              restart, // Phase change, back to step 0
	input  logic              hold,    // Freeze during MFC waits
	input  logic [`STEP_W-1:0] length,
	output logic [`STEP_W-1:0] step,
	output logic              last
);

	always_ff @(posedge Clk)
	begin
		if (RESET)
			step <= '0;
		else if (restart)
			step <= '0; // Wins over hold when MFC ends a wait
		else if (!hold)
			step <= step + 1'b1;
	end

	// Final micro-step of the current phase
	assign last = (step == `STEP_W'(length - 1'b1));

endmodule

// File: tb/controlUnitTb.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module controlUnitTb;

	localparam int CYCLE_LIMIT = 400; // Seven instructions of at most ~25 cycles plus reset and margin
	localparam int ALU_PC_GAP  = 6;   // IRLOAD, DECODE, three EXEC steps, then PCADV step 1
	localparam int NOP_PC_GAP  = 3;   // IRLOAD, DECODE, then PCADV step 1

	logic                 Clk;
	logic                 RESET;
	logic [`WORD_W-1:0]   irOut;
	logic                 MFC;
	cuPkg::enables_t      enables;
	cuPkg::clears_t       clears;
	cuPkg::muxSel_t       muxSel;
	cuPkg::regAddr_t      regAddr;
	logic [`ALU_OP_W-1:0] aluOp;
	logic [`ALU_OP_W-1:0] ramOpCode;

	int cycleCount;
	int testErrors;
	int passCount;
	int failCount;
	logic [15:0] lfsr;

	// Event record of one instruction in cycles from the trace start
	int irAt, pcAt, marAt, ramAt, mfcAt, mdrAt, rfAt;
	int npcPre, marCount, mdrCount, rfCount, psrCount;
	logic npcWithPc, ramGap, fetchOrderBad, irBeforeMfc;
	logic [`ALU_OP_W-1:0] fetchRamOp, ramOp, rfAluOp;
	cuPkg::muxSel_t  rfSel, mdrSel, pcSel;
	cuPkg::regAddr_t rfAddr, mdrAddr;

	controlUnit dut
	(
		.Clk       (Clk),
		.RESET     (RESET),
		.irOut     (irOut),
		.MFC       (MFC),
		.enables   (enables),
		.clears    (clears),
		.muxSel    (muxSel),
		.regAddr   (regAddr),
		.aluOp     (aluOp),
		.ramOpCode (ramOpCode)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#20 Clk = ~Clk; // 40 ns period
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Format 3 word with simm13 or rs2 in low
	function automatic logic [31:0] format3(input logic [1:0] op, input logic [4:0] rd,
		input logic [5:0] op3, input logic [4:0] rs1, input logic i, input logic [12:0] low);
		return {op, rd, op3, rs1, i, low};
	endfunction

	function automatic logic [31:0] sethiWord(input logic [4:0] rd, input logic [21:0] imm22);
		return {2'b00, rd, `OP2_SETHI, imm22};
	endfunction

	// Memory model answers each ramEn after 0 to 3 extra cycles
	initial
	begin : mfcResponder
		int delay;
		MFC  = 1'b0;
		lfsr = 16'd30915;
		forever
		begin
			@(negedge Clk);
			if (enables.ramEn === 1'b1)
			begin
				delay = 0;
				repeat (2)
				begin
					lfsr  = lfsrStep(lfsr); // One step per bit
					delay = (delay << 1) | lfsr[0];
				end
				repeat (delay + 1)
					@(posedge Clk);
				#2 MFC = 1'b1;
				@(posedge Clk);
				#2 MFC = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		cycleCount = 0;
		forever
		begin
			@(posedge Clk);
			cycleCount++;
			if (cycleCount >= CYCLE_LIMIT)
			begin
				$display("Timeout after %0d cycles, the run hung waiting on the DUT", cycleCount);
				$display("** FAIL **");
				$finish;
			end
		end
	end

	task automatic reportMismatch(input string testName, input string what,
		input int expected, input int actual);
		$display("FAILED %s: %s expected %0h actual %0h", testName, what, expected, actual);
		testErrors++;
	endtask

	task automatic reportProblem(input string testName, input string what);
		$display("Error in %s: %s", testName, what);
		testErrors++;
	endtask

	task automatic finishTest(input string testName);
		if (testErrors == 0)
		begin
			$display("%s: ok", testName);
			passCount++;
		end
		else
		begin
			$display("%s: %0d errors", testName, testErrors);
			failCount++;
		end
	endtask

	// Follows outputs at each falling edge from fetch through the pcEn pulse
	task automatic traceInstr();
		int n;
		logic fetchMar;
		logic fetchMfc;
		logic fetchRamSeen;
		logic done;
		n = 0;
		fetchMar = 1'b0;
		fetchMfc = 1'b0;
		fetchRamSeen = 1'b0;
		done = 1'b0;
		irAt = -1;
		pcAt = -1;
		marAt = -1;
		ramAt = -1;
		mfcAt = -1;
		mdrAt = -1;
		rfAt = -1;
		npcPre = 0;
		marCount = 0;
		mdrCount = 0;
		rfCount = 0;
		psrCount = 0;
		npcWithPc = 1'b0;
		ramGap = 1'b0;
		fetchOrderBad = 1'b0;
		irBeforeMfc = 1'b0;
		fetchRamOp = '1;
		ramOp = '1;
		while (!done)
		begin
			@(negedge Clk);
			n++;
			if (irAt < 0)
			begin
				if (enables.npcEn && !fetchMar)
					npcPre++; // INIT pulse
				if (enables.marEn)
					fetchMar = 1'b1;
				if (enables.ramEn && !fetchRamSeen)
				begin
					fetchRamSeen = 1'b1;
					fetchRamOp   = ramOpCode;
					fetchOrderBad = !fetchMar;
				end
				// MFC must be seen in an earlier cycle than irEn
				if (enables.irEn)
				begin
					irAt = n;
					irBeforeMfc = !fetchMfc;
				end
				if (MFC)
					fetchMfc = 1'b1;
			end
			else
			begin
				if (enables.marEn)
				begin
					marCount++;
					marAt = n;
				end
				if (enables.ramEn)
				begin
					if (ramAt < 0)
					begin
						ramAt = n;
						ramOp = ramOpCode;
					end
				end
				else if (ramAt >= 0 && mfcAt < 0)
					ramGap = 1'b1; // Level dropped while waiting
				if (MFC && ramAt >= 0 && mfcAt < 0)
					mfcAt = n;
				if (enables.mdrEn)
				begin
					mdrCount++;
					mdrAt   = n;
					mdrSel  = muxSel;
					mdrAddr = regAddr;
				end
				if (enables.rfEn)
				begin
					rfCount++;
					rfAt    = n;
					rfSel   = muxSel;
					rfAddr  = regAddr;
					rfAluOp = aluOp;
				end
				if (enables.psrEn)
					psrCount++;
				if (enables.pcEn)
				begin
					pcAt = n;
					pcSel = muxSel;
					npcWithPc = enables.npcEn;
					done = 1'b1;
				end
			end
		end
	endtask

	task automatic presentInstr(input logic [31:0] instr);
		@(posedge Clk);
		#2 irOut = instr;
	endtask

	task automatic resetAndFirstFetch();
		string name;
		name = "reset and fetch";
		testErrors = 0;
		@(negedge Clk); // RESET still high in INIT step 0
		if (clears !== 2'b11)
			reportMismatch(name, "clears in reset", 2'b11, clears);
		if (enables !== '0)
			reportMismatch(name, "enables in reset", 0, enables);
		@(posedge Clk);
		#2 RESET = 1'b0;
		traceInstr(); // irOut of zero runs as a no-op
		if (npcPre !== 1)
			reportMismatch(name, "npcEn pulses before fetch", 1, npcPre);
		if (fetchOrderBad)
			reportProblem(name, "fetch ramEn rose before marEn");
		if (fetchRamOp !== `RAM_LOAD_WORD)
			reportMismatch(name, "fetch ramOpCode", `RAM_LOAD_WORD, fetchRamOp);
		if (irBeforeMfc)
			reportProblem(name, "irEn rose before MFC was seen");
		finishTest(name);
	endtask

	task automatic sethiToRd();
		string name;
		name = "sethi";
		testErrors = 0;
		presentInstr(sethiWord(5'd5, 22'h2ABCD));
		traceInstr();
		if (rfCount !== 1)
			reportMismatch(name, "rfEn pulses", 1, rfCount);
		if (rfAddr.inPC !== 5'd5)
			reportMismatch(name, "inPC at rfEn", 5, rfAddr.inPC);
		if (rfAddr.inPA !== 5'd0)
			reportMismatch(name, "inPA at rfEn", 0, rfAddr.inPA);
		if (rfSel.ext !== cuPkg::EXT_IMM22HI)
			reportMismatch(name, "ext at rfEn", cuPkg::EXT_IMM22HI, rfSel.ext);
		if (pcAt - irAt !== ALU_PC_GAP)
			reportMismatch(name, "irEn to pcEn cycles", ALU_PC_GAP, pcAt - irAt);
		if (npcWithPc !== 1'b1)
			reportProblem(name, "npcEn did not pulse with pcEn");
		if (pcSel.aluA !== cuPkg::A_NPC)
			reportMismatch(name, "aluA at pcEn", cuPkg::A_NPC, pcSel.aluA);
		if (pcSel.aluB !== cuPkg::B_FOUR)
			reportMismatch(name, "aluB at pcEn", cuPkg::B_FOUR, pcSel.aluB);
		if (pcSel.pcIn !== cuPkg::PCIN_NPC)
			reportMismatch(name, "pcIn at pcEn", cuPkg::PCIN_NPC, pcSel.pcIn);
		if (psrCount !== 0)
			reportMismatch(name, "psrEn pulses", 0, psrCount);
		finishTest(name);
	endtask

	task automatic arithmetic(input string name, input logic [5:0] op3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic useImm, input logic [12:0] low);
		cuPkg::aluBSel_e expB;
		int expPsr;
		testErrors = 0;
		expB   = useImm ? cuPkg::B_EXTENDER : cuPkg::B_REGPORT;
		expPsr = op3[4] ? 1 : 0; // cc forms have op3 bit 4 set
		presentInstr(format3(`OP_ARITH, rd, op3, rs1, useImm, low));
		traceInstr();
		if (rfCount !== 1)
			reportMismatch(name, "rfEn pulses", 1, rfCount);
		if (rfAluOp !== op3)
			reportMismatch(name, "aluOp at rfEn", op3, rfAluOp);
		if (rfAddr.inPA !== rs1)
			reportMismatch(name, "inPA at rfEn", rs1, rfAddr.inPA);
		if (rfAddr.inPC !== rd)
			reportMismatch(name, "inPC at rfEn", rd, rfAddr.inPC);
		if (rfSel.aluB !== expB)
			reportMismatch(name, "aluB at rfEn", expB, rfSel.aluB);
		if (!useImm && rfAddr.inPB !== low[4:0])
			reportMismatch(name, "inPB at rfEn", low[4:0], rfAddr.inPB);
		if (psrCount !== expPsr)
			reportMismatch(name, "psrEn pulses", expPsr, psrCount);
		if (pcAt - irAt !== ALU_PC_GAP)
			reportMismatch(name, "irEn to pcEn cycles", ALU_PC_GAP, pcAt - irAt);
		finishTest(name);
	endtask

	task automatic loadHalfword();
		string name;
		name = "load halfword";
		testErrors = 0;
		presentInstr(format3(`OP_MEM, 5'd8, `OP3_LDUH, 5'd4, 1'b1, 13'd16));
		traceInstr();
		if (marCount !== 1)
			reportMismatch(name, "marEn pulses", 1, marCount);
		if (ramAt <= marAt)
			reportProblem(name, "ramEn did not follow marEn");
		if (ramOp !== `OP3_LDUH)
			reportMismatch(name, "ramOpCode", `OP3_LDUH, ramOp);
		if (mfcAt < 0)
			reportProblem(name, "no MFC seen during the memory wait");
		if (ramGap)
			reportProblem(name, "ramEn dropped before MFC");
		if (mdrCount !== 1)
			reportMismatch(name, "mdrEn pulses", 1, mdrCount);
		if (mdrAt <= mfcAt)
			reportProblem(name, "mdrEn came before MFC");
		if (mdrSel.mdr !== cuPkg::MDR_MEMORY)
			reportMismatch(name, "mdr select", cuPkg::MDR_MEMORY, mdrSel.mdr);
		if (rfCount !== 1)
			reportMismatch(name, "rfEn pulses", 1, rfCount);
		if (rfAt <= mdrAt)
			reportProblem(name, "rfEn came before mdrEn");
		if (rfAddr.inPC !== 5'd8)
			reportMismatch(name, "inPC at rfEn", 8, rfAddr.inPC);
		if (pcAt <= rfAt)
			reportProblem(name, "pcEn came before rfEn");
		finishTest(name);
	endtask

	task automatic storeByte();
		string name;
		name = "store byte";
		testErrors = 0;
		presentInstr(format3(`OP_MEM, 5'd17, `OP3_STB, 5'd2, 1'b0, 13'd6));
		traceInstr();
		if (marCount !== 1)
			reportMismatch(name, "marEn pulses", 1, marCount);
		if (mdrCount !== 1)
			reportMismatch(name, "mdrEn pulses", 1, mdrCount);
		if (mdrAt <= marAt)
			reportProblem(name, "mdrEn came before marEn");
		if (mdrAddr.inPA !== 5'd17)
			reportMismatch(name, "inPA at mdrEn", 17, mdrAddr.inPA);
		if (mdrSel.mdr !== cuPkg::MDR_REGPORT)
			reportMismatch(name, "mdr select", cuPkg::MDR_REGPORT, mdrSel.mdr);
		if (ramAt <= mdrAt)
			reportProblem(name, "ramEn rose before the data was staged");
		if (ramOp !== `OP3_STB)
			reportMismatch(name, "ramOpCode", `OP3_STB, ramOp);
		if (mfcAt < 0)
			reportProblem(name, "no MFC seen during the memory wait");
		if (ramGap)
			reportProblem(name, "ramEn dropped before MFC");
		if (rfCount !== 0)
			reportMismatch(name, "rfEn pulses", 0, rfCount);
		if (pcAt <= mfcAt)
			reportProblem(name, "pcEn came before MFC");
		finishTest(name);
	endtask

	task automatic unknownOpcode();
		string name;
		name = "unknown opcode";
		testErrors = 0;
		presentInstr(format3(`OP_MEM, 5'd1, 6'h3F, 5'd1, 1'b0, 13'd1));
		traceInstr();
		if (rfCount !== 0)
			reportMismatch(name, "rfEn pulses", 0, rfCount);
		if (marCount !== 0)
			reportMismatch(name, "marEn pulses", 0, marCount);
		if (psrCount !== 0)
			reportMismatch(name, "psrEn pulses", 0, psrCount);
		if (pcAt - irAt !== NOP_PC_GAP)
			reportMismatch(name, "irEn to pcEn cycles", NOP_PC_GAP, pcAt - irAt);
		finishTest(name);
	endtask

	initial
	begin
		RESET = 1'b1;
		irOut = '0;
		passCount = 0;
		failCount = 0;
		resetAndFirstFetch();
		sethiToRd();
		arithmetic("arith reg", 6'h02, 5'd3, 5'd7, 1'b0, 13'd9);       // OR with cc clear
		arithmetic("arith imm cc", 6'h10, 5'd20, 5'd12, 1'b1, 13'h1F3); // ADDcc
		loadHalfword();
		storeByte();
		unknownOpcode();
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
